// File: filelist.f
+incdir+rtl
rtl/y86_pkg.sv
rtl/src_select.sv
rtl/dst_select.sv
rtl/register_file.sv
rtl/decode_writeback.sv
testbench/tb_decode_writeback.sv

// File: rtl/decode_writeback.sv
`timescale 1ns/1ps
`include "y86_defs.svh"

module decode_writeback (
  input  logic             clk,
  input  logic             rst,
  input  logic             req,
  output logic             ack,
  input  y86_pkg::icode_t  icode,
  input  y86_pkg::reg_id_t ra,
  input  y86_pkg::reg_id_t rb,
  input  logic             cnd,
  input  y86_pkg::word_t   val_e,
  input  y86_pkg::word_t   val_m,
  output y86_pkg::word_t   val_a,
  output y86_pkg::word_t   val_b
);

  import y86_pkg::*;

  reg_id_t src_a; // operand read ids
  reg_id_t src_b;
  reg_id_t dst_e; // write-back ids
  reg_id_t dst_m;

  // both selectors decode the same held offer side by side
  src_select u_src_select (
    .icode (icode),
    .ra    (ra),
    .rb    (rb),
    .src_a (src_a),
    .src_b (src_b)
  );

  dst_select u_dst_select (
    .icode (icode),
    .cnd   (cnd),
    .ra    (ra),
    .rb    (rb),
    .dst_e (dst_e),
    .dst_m (dst_m)
  );

  register_file u_register_file (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .ack   (ack),
    .src_a (src_a),
    .src_b (src_b),
    .dst_e (dst_e),
    .dst_m (dst_m),
    .val_e (val_e),
    .val_m (val_m),
    .val_a (val_a),
    .val_b (val_b)
  );

endmodule

// File: rtl/dst_select.sv
`timescale 1ns/1ps
`include "y86_defs.svh"

module dst_select (
  input  y86_pkg::icode_t  icode,
  input  logic             cnd,
  input  y86_pkg::reg_id_t ra,
  input  y86_pkg::reg_id_t rb,
  output y86_pkg::reg_id_t dst_e,
  output y86_pkg::reg_id_t dst_m
);

  import y86_pkg::*;

  always_comb
  begin
    dst_e = `REG_NONE; // nothing written by default
    dst_m = `REG_NONE;
    case (icode)
      I_RRMOVQ:
      begin
        if (cnd)
        begin
          dst_e = rb; // failed cmov keeps rb as it was
        end
      end
      I_IRMOVQ:
      begin
        dst_e = rb;
      end
      I_OPQ:
      begin
        dst_e = rb; // alu result
      end
      I_MRMOVQ:
      begin
        dst_m = ra; // loaded word
      end
      I_CALL, I_RET, I_PUSHQ:
      begin
        dst_e = `REG_RSP; // adjusted stack pointer
      end
      I_POPQ:
      begin
        dst_e = `REG_RSP;
        dst_m = ra; // wins over dst_e when ra is rsp
      end
      I_HALT, I_NOP, I_RMMOVQ, I_JXX:
      begin
        dst_e = `REG_NONE;
        dst_m = `REG_NONE;
      end
      default:
      begin
        dst_e = `REG_NONE;
        dst_m = `REG_NONE;
      end
    endcase
  end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ps
`include "y86_defs.svh"

module register_file (
  input  logic             clk,
  input  logic             rst,
  input  logic             req,
  output logic             ack,
  input  y86_pkg::reg_id_t src_a,
  input  y86_pkg::reg_id_t src_b,
  input  y86_pkg::reg_id_t dst_e,
  input  y86_pkg::reg_id_t dst_m,
  input  y86_pkg::word_t   val_e,
  input  y86_pkg::word_t   val_m,
  output y86_pkg::word_t   val_a,
  output y86_pkg::word_t   val_b
);

  import y86_pkg::*;

  word_t regs [`REG_COUNT]; // architectural registers 0 to 14

  logic  accept;  // new offer taken this edge
  logic  we_e;
  logic  we_m;
  word_t rd_a;    // contents before this edge's writes
  word_t rd_b;

  // idle means ack low; a req seen then is a fresh offer
  assign accept = req && !ack;

  assign we_e = accept && (dst_e != `REG_NONE);
  assign we_m = accept && (dst_m != `REG_NONE);

  // the no-register id reads as zero
  always_comb
  begin
    rd_a = '0;
    rd_b = '0;
    if (src_a != `REG_NONE)
    begin
      rd_a = regs[src_a];
    end
    if (src_b != `REG_NONE)
    begin
      rd_b = regs[src_b];
    end
  end

  // storage and write-back of the accepted instruction
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
      begin
        regs[i] <= word_t'(i); // register i starts at i
      end
    end
    else
    begin
      if (we_e)
      begin
        regs[dst_e] <= val_e;
      end
      if (we_m)
      begin
        regs[dst_m] <= val_m; // later assignment, so m beats e
      end
    end
  end

  // operands captured on the same edge as the writes
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      val_a <= '0;
      val_b <= '0;
    end
    else if (accept)
    begin
      val_a <= rd_a;
      val_b <= rd_b;
    end
  end

  // four-phase handshake with ack held until req drops
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack <= 1'b0;
    end
    else if (accept)
    begin
      ack <= 1'b1;
    end
    else if (ack && !req)
    begin
      ack <= 1'b0; // release, ready for the next offer
    end
  end

  // ack only answers a req sampled at the edge before
  ack_after_req: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req))
    else $error("register_file: ack rose without a request");

  // the offer, and so the selected destinations, must hold while acked
  dst_held: assert property (@(posedge clk) disable iff (rst)
    ack |-> $stable({dst_e, dst_m}))
    else $error("register_file: destination ids changed while ack was high");

endmodule

// File: rtl/src_select.sv
`timescale 1ns/1ps
`include "y86_defs.svh"

module src_select (
  input  y86_pkg::icode_t  icode,
  input  y86_pkg::reg_id_t ra,
  input  y86_pkg::reg_id_t rb,
  output y86_pkg::reg_id_t src_a,
  output y86_pkg::reg_id_t src_b
);

  import y86_pkg::*;

  always_comb
  begin
    src_a = `REG_NONE; // no read unless decoded below
    src_b = `REG_NONE;
    case (icode)
      I_RRMOVQ:
      begin
        src_a = ra; // move source, cmov or not
      end
      I_RMMOVQ:
      begin
        src_a = ra; // data to store
        src_b = rb; // base address
      end
      I_MRMOVQ:
      begin
        src_b = rb; // base address
      end
      I_OPQ:
      begin
        src_a = ra;
        src_b = rb;
      end
      I_CALL:
      begin
        src_b = `REG_RSP;
      end
      I_RET, I_POPQ:
      begin
        src_a = `REG_RSP; // old rsp is the load address
        src_b = `REG_RSP;
      end
      I_PUSHQ:
      begin
        src_a = ra; // value pushed
        src_b = `REG_RSP;
      end
      I_HALT, I_NOP, I_IRMOVQ, I_JXX:
      begin
        src_a = `REG_NONE;
        src_b = `REG_NONE;
      end
      default:
      begin
        src_a = `REG_NONE; // undefined codes read nothing
        src_b = `REG_NONE;
      end
    endcase
  end

  // a known instruction must always give known source ids
  always_comb
  begin
    if (!$isunknown({icode, ra, rb}))
    begin
      assert (!$isunknown({src_a, src_b}))
        else $error("src_select: unknown source id for icode %h", icode);
    end
  end

endmodule

// File: rtl/y86_defs.svh
`ifndef Y86_DEFS_SVH
`define Y86_DEFS_SVH

// architectural register file
`define REG_COUNT 15

// width of one register or one value
`define WORD_BITS 64

// field widths of a decoded instruction
`define REG_ID_BITS 4
`define ICODE_BITS 4

// register ids with a fixed meaning
`define REG_RSP 4'd4   // stack pointer
`define REG_NONE 4'hf  // reads as zero and drops writes

`endif

// File: rtl/y86_pkg.sv
`include "y86_defs.svh"

package y86_pkg;

  // y86-64 instruction codes from the upper nibble of the first byte
  typedef enum logic [`ICODE_BITS-1:0] {
    I_HALT   = 4'h0,
    I_NOP    = 4'h1,
    I_RRMOVQ = 4'h2, // also cmovxx
    I_IRMOVQ = 4'h3,
    I_RMMOVQ = 4'h4,
    I_MRMOVQ = 4'h5,
    I_OPQ    = 4'h6,
    I_JXX    = 4'h7,
    I_CALL   = 4'h8,
    I_RET    = 4'h9,
    I_PUSHQ  = 4'ha,
    I_POPQ   = 4'hb
  } icode_t;

  // register id 0 to 14 plus the no-register code
  typedef logic [`REG_ID_BITS-1:0] reg_id_t;

  // register contents and operand values
  typedef logic [`WORD_BITS-1:0] word_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_decode_writeback \
    -Mdir obj_dir -o sim_decode_writeback \
  && ./obj_dir/sim_decode_writeback | tee /dev/stderr | grep -q "TEST PASSED" \
  && echo "simulation ok" \
  || { echo "simulation did not pass"; exit 1; }

exit 0

// File: testbench/regfile_testdata.txt
// icode ra rb cnd val_e val_m expected_val_a expected_val_b
// all hex, one instruction per line, ff in the icode column ends the list
6 2 3 0 1111 0 2 3
3 f 5 0 a5a5a5a5a5a5a5a5 0 0 0
2 5 6 1 a5a5a5a5a5a5a5a5 0 a5a5a5a5a5a5a5a5 0
6 7 7 0 77770000 0 7 7
6 7 3 0 2222 0 77770000 1111
// conditional move, not taken then taken
2 1 8 0 dead 0 1 0
6 8 9 0 99 0 8 9
2 1 8 1 beef 0 1 0
4 8 9 0 0 0 beef 99
// stack: call, pushq, ret, popq
8 f f 0 3f8 0 0 4
a 6 f 0 3f0 0 a5a5a5a5a5a5a5a5 3f8
9 f f 0 3f8 1234 3f0 3f0
b a f 0 400 cafe 3f8 3f8
4 a 4 0 0 0 cafe 400
// loads, popq into rsp keeps val_m
5 b 4 0 408 0123456789abcdef 0 400
b 4 f 0 408 5555 400 400
6 b 4 0 6666 0 0123456789abcdef 5555
4 4 4 0 0 0 6666 6666
// no register access at all
1 2 3 0 ffff eeee 0 0
7 f f 0 ffff 0 0 0
0 f f 0 ffff 0 0 0
4 2 3 0 0 0 2 2222
// chained updates under random gaps
6 c c 0 100 0 c c
6 c c 0 200 0 100 100
6 c d 0 300 0 200 d
6 d e 0 400 0 300 e
6 e c 0 500 0 400 200
4 c d 0 0 0 500 300
4 e 0 0 0 0 400 0
3 f f 0 dead 0 0 0
6 0 1 0 1 0 0 1
4 c d 0 0 0 500 300
ff 0 0 0 0 0 0 0

// File: testbench/tb_decode_writeback.sv
`timescale 1ns/1ps

module tb_decode_writeback;

  import y86_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 8;
  localparam int FIELDS = 8;       // words per test record
  localparam int MAX_TESTS = 64;
  localparam int ACK_WAIT = 4;     // cycles allowed for each ack edge
  localparam logic [63:0] END_MARK = 64'hff;

  logic    clk;
  logic    rst;
  logic    req;
  logic    ack;
  icode_t  icode;
  reg_id_t ra;
  reg_id_t rb;
  logic    cnd;
  word_t   val_e;
  word_t   val_m;
  word_t   val_a;
  word_t   val_b;

  logic [63:0] test_mem [0:FIELDS*MAX_TESTS-1];

  int          num_tests;
  int          fail_count;
  int          pass_count;
  int          test_errors;  // errors in the test now running
  int          cur_test;
  logic        data_loaded;
  logic [31:0] rng_state;

  decode_writeback UUT (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .ack   (ack),
    .icode (icode),
    .ra    (ra),
    .rb    (rb),
    .cnd   (cnd),
    .val_e (val_e),
    .val_m (val_m),
    .val_a (val_a),
    .val_b (val_b)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t expected);
    if (got !== expected)
    begin
      $display("Error: %s got %h expected %h", name, got, expected);
      test_errors++;
    end
  endtask

  task automatic check_ack(input logic got, input logic expected, input string when);
    if (got !== expected)
    begin
      $display("Handshake problem in test %0d: ack was %s %s", cur_test,
               got ? "high" : "low", when);
      test_errors++;
    end
  endtask

  task automatic run_test(input int idx);
    int    base;
    int    waited;
    int    gap;
    word_t exp_a;
    word_t exp_b;
    base = idx * FIELDS;
    cur_test = idx;
    test_errors = 0;
    exp_a = test_mem[base + 6];
    exp_b = test_mem[base + 7];
    check_ack(ack, 1'b0, "before the offer was made");
    icode = icode_t'(test_mem[base][3:0]);
    ra = test_mem[base + 1][3:0];
    rb = test_mem[base + 2][3:0];
    cnd = test_mem[base + 3][0];
    val_e = test_mem[base + 4];
    val_m = test_mem[base + 5];
    req = 1'b1;
    waited = 0;
    while (!ack && waited < ACK_WAIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!ack)
    begin
      $display("Handshake problem in test %0d: ack never rose after req", idx);
      test_errors++;
    end
    else if (waited != 1)
    begin
      $display("Handshake problem in test %0d: ack took %0d cycles instead of one",
               idx, waited);
      test_errors++;
    end
    check_word("val_a", val_a, exp_a);
    check_word("val_b", val_b, exp_b);
    req = 1'b0; // offer stays on the inputs until ack falls
    waited = 0;
    while (ack && waited < ACK_WAIT)
    begin
      @(negedge clk);
      waited++;
    end
    check_ack(ack, 1'b0, "long after req was lowered");
    if (!ack && waited != 1)
    begin
      $display("Handshake problem in test %0d: ack took %0d cycles to fall instead of one",
               idx, waited);
      test_errors++;
    end
    gap = int'(rng_state[1:0]);
    rng_state = next_random(rng_state);
    for (int i = 0; i < gap; i++)
    begin
      @(negedge clk);
      check_ack(ack, 1'b0, "during an idle gap with no request");
    end
    if (test_errors == 0)
    begin
      pass_count++;
      $display("test %0d %s: ok", idx, icode.name());
    end
    else
    begin
      fail_count++;
      $display("test %0d %s: %0d mismatches", idx, icode.name(), test_errors);
    end
  endtask

  // watchdog scaled by the number of records
  initial
  begin
    wait (data_loaded);
    repeat (num_tests * 10 + 20) @(posedge clk);
    $display("Timeout: the run did not end within %0d clock periods",
             num_tests * 10 + 20);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    rst = 1'b1;
    req = 1'b0;
    icode = I_NOP;
    ra = 4'hf;
    rb = 4'hf;
    cnd = 1'b0;
    val_e = '0;
    val_m = '0;
    num_tests = 0;
    fail_count = 0;
    pass_count = 0;
    test_errors = 0;
    cur_test = 0;
    data_loaded = 1'b0;
    rng_state = 32'd37972;
    $readmemh("testbench/regfile_testdata.txt", test_mem);
    while (num_tests < MAX_TESTS && test_mem[num_tests * FIELDS] != END_MARK)
    begin
      num_tests++;
    end
    data_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_ack(ack, 1'b0, "right after reset");
    check_word("val_a", val_a, '0);
    check_word("val_b", val_b, '0);
    if (test_errors == 0)
    begin
      $display("reset: ok");
    end
    else
    begin
      fail_count++;
      $display("reset: %0d mismatches", test_errors);
    end
    if (num_tests == 0)
    begin
      $display("The data file held no test records");
      fail_count++;
    end
    for (int t = 0; t < num_tests; t++)
    begin
      run_test(t);
    end
    $display("tests run %0d, passed %0d, failed %0d", num_tests, pass_count, fail_count);
    if (fail_count == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
